/* verilog/lullaby_song.svh */
`ifndef LULLABY_SONG_SVH
`define LULLABY_SONG_SVH

// Entry k is the note played at step k, phrases are split by blank lines
localparam note_t song_table [SONG_LENGTH] = '{
        NOTE_T4,
        NOTE_T5,
        NOTE_T4,
        NOTE_T3,
        NOTE_T1,
        NOTE_T3,
        NOTE_T1,
        NOTE_T1,
        NOTE_REST,
        NOTE_REST,
        NOTE_REST,
        NOTE_REST,

        NOTE_T1,
        NOTE_T5,
        NOTE_T5,
        NOTE_T5,
        NOTE_T7,
        NOTE_T9,
        NOTE_T7,
        NOTE_T7,
        NOTE_REST,
        NOTE_REST,
        NOTE_REST,
        NOTE_REST,

        NOTE_T3,
        NOTE_T2,
        NOTE_T3,
        NOTE_T3,
        NOTE_T2,
        NOTE_T3,
        NOTE_T5,
        NOTE_T5,
        NOTE_REST,
        NOTE_REST,
        NOTE_REST,
        NOTE_REST,

        NOTE_T4,
        NOTE_T4,
        NOTE_T4,
        NOTE_T5,
        NOTE_T4,
        NOTE_T5,
        NOTE_T7,
        NOTE_T7,
        NOTE_REST,
        NOTE_REST,
        NOTE_REST,
        NOTE_REST,

        NOTE_T9,
        NOTE_T9,
        NOTE_T9,
        NOTE_T9,
        NOTE_T8,
        NOTE_T9,
        NOTE_T11,
        NOTE_T11,
        NOTE_REST,
        NOTE_REST,
        NOTE_REST,
        NOTE_REST,

        NOTE_T7,
        NOTE_T7,
        NOTE_T7,
        NOTE_T7,
        NOTE_T6,
        NOTE_T7,
        NOTE_T11,
        NOTE_T11,
        NOTE_REST,
        NOTE_REST,
        NOTE_REST,
        NOTE_REST,

        NOTE_T5,
        NOTE_T7,
        NOTE_T5,
        NOTE_T4,
        NOTE_T5,
        NOTE_T7,
        NOTE_T3,
        NOTE_T3,
        NOTE_REST,
        NOTE_REST,
        NOTE_REST,
        NOTE_REST,

        NOTE_T4,
        NOTE_T5,
        NOTE_T4,
        NOTE_T3,
        NOTE_T1,
        NOTE_T3,
        NOTE_T1,
        NOTE_T1,
        NOTE_REST,
        NOTE_REST,
        NOTE_REST,

        // Closing phrase, played twice with a different ending
        NOTE_T4,
        NOTE_T7,
        NOTE_T7,
        NOTE_T6,
        NOTE_T5,
        NOTE_T4,
        NOTE_T5,
        NOTE_T3,
        NOTE_T1,
        NOTE_T1,
        NOTE_REST,
        NOTE_REST,
        NOTE_REST,

        NOTE_T4,
        NOTE_T7,
        NOTE_T7,
        NOTE_T6,
        NOTE_T5,
        NOTE_T4,
        NOTE_T5,
        NOTE_T3,
        NOTE_T1,
        NOTE_T1,
        NOTE_T1,
        NOTE_T1,
        NOTE_T1,
        NOTE_T1         // Last step, the player wraps to step 0 after it
};

`endif

/* verilog/lullaby_pkg.sv */
package lullaby_pkg;

        // Width of beat, one bit per tone of the scale
        localparam int TONE_COUNT  = 13;

        // Notes in one pass of the song
        localparam int SONG_LENGTH = 122;

        localparam int STEP_WIDTH  = 7;   // Enough to index SONG_LENGTH notes

        typedef logic [STEP_WIDTH-1:0] step_t;

        // NOTE_Tk sounds bit k of beat and NOTE_REST sounds nothing
        typedef enum logic [3:0]
        {
                NOTE_REST,
                NOTE_T0,
                NOTE_T1,
                NOTE_T2,
                NOTE_T3,
                NOTE_T4,
                NOTE_T5,
                NOTE_T6,
                NOTE_T7,
                NOTE_T8,
                NOTE_T9,
                NOTE_T10,
                NOTE_T11,
                NOTE_T12
        } note_t;

        typedef enum logic
        {
                PLAYER_OFF,
                PLAYER_ON
        } player_state_t;

        // The song itself, indexed by step
        `include "lullaby_song.svh"

endpackage

/* verilog/player_control.sv */
`timescale 1ns/100ps

module player_control
        import lullaby_pkg::*;
(
        input  logic  clock,
        input  logic  reset,
        input  logic  start,
        input  logic  stop,
        output logic  playing,
        output step_t step
);

        player_state_t state;
        player_state_t next_state;
        step_t         next_step;
        logic          last_step;

        assign last_step = (step == step_t'(SONG_LENGTH - 1));

        always_comb
        begin
                next_state = state;
                next_step  = step;

                if (stop)
                begin
                        // Stop has priority over start and over playing on
                        next_state = PLAYER_OFF;
                        next_step  = '0;
                end
                else
                begin
                        case (state)
                                PLAYER_OFF:
                                begin
                                        if (start)
                                        begin
                                                next_state = PLAYER_ON;
                                        end
                                        next_step = '0;   // Every start begins at the first note
                                end

                                PLAYER_ON:
                                begin
                                        // Start is ignored here and the song just keeps going
                                        if (last_step)
                                                next_step = '0;
                                        else
                                                next_step = step + step_t'(1);
                                end
                        endcase
                end
        end

        always_ff @(posedge clock or posedge reset)
        begin
                if (reset)
                begin
                        state <= PLAYER_OFF;
                        step  <= '0;
                end
                else
                begin
                        state <= next_state;
                        step  <= next_step;
                end
        end

        assign playing = (state == PLAYER_ON);

endmodule

/* verilog/song_rom.sv */
`timescale 1ns/100ps

module song_rom
        import lullaby_pkg::*;
(
        input  logic                  clock,
        input  logic                  reset,
        input  logic                  playing,
        input  step_t                 step,
        output logic [TONE_COUNT-1:0] beat
);

        note_t                 note;
        logic [TONE_COUNT-1:0] tone;

        assign note = song_table[step];

        // One-hot decode of the note, a rest leaves every bit low
        always_comb
        begin
                tone = '0;
                case (note)
                        NOTE_T0:  tone[0]  = 1'b1;
                        NOTE_T1:  tone[1]  = 1'b1;
                        NOTE_T2:  tone[2]  = 1'b1;
                        NOTE_T3:  tone[3]  = 1'b1;
                        NOTE_T4:  tone[4]  = 1'b1;
                        NOTE_T5:  tone[5]  = 1'b1;
                        NOTE_T6:  tone[6]  = 1'b1;
                        NOTE_T7:  tone[7]  = 1'b1;
                        NOTE_T8:  tone[8]  = 1'b1;
                        NOTE_T9:  tone[9]  = 1'b1;
                        NOTE_T10: tone[10] = 1'b1;
                        NOTE_T11: tone[11] = 1'b1;
                        NOTE_T12: tone[12] = 1'b1;
                        default:  tone     = '0;
                endcase
        end

        // Output is one cycle behind the step counter
        always_ff @(posedge clock or posedge reset)
        begin
                if (reset)
                        beat <= '0;
                else if (!playing)
                        beat <= '0;   // Silent whenever the player is off
                else
                        beat <= tone;
        end

endmodule

/* verilog/lullaby.sv */
`timescale 1ns/100ps

module lullaby
        import lullaby_pkg::*;
(
        input  logic                  clock,
        input  logic                  reset,
        input  logic                  start,
        input  logic                  stop,
        output logic [TONE_COUNT-1:0] beat
);

        logic  playing;
        step_t step;

        // Off/on control and the position in the song
        player_control player_control0
        (
                .clock   (clock),
                .reset   (reset),
                .start   (start),
                .stop    (stop),
                .playing (playing),
                .step    (step)
        );

        song_rom song_rom0   // Note lookup and registered tone output
        (
                .clock   (clock),
                .reset   (reset),
                .playing (playing),
                .step    (step),
                .beat    (beat)
        );

endmodule

/* sim/lullaby_tb.sv */
`timescale 1ns/100ps

module lullaby_tb
        import lullaby_pkg::*;
();

        localparam int CLOCK_PERIOD    = 8;
        localparam int WATCHDOG_CYCLES = 16 + 3 * SONG_LENGTH + 4000 + 1000;

        logic                  clock;
        logic                  reset;
        logic                  start;
        logic                  stop;
        logic [TONE_COUNT-1:0] beat;

        logic                  model_on;
        step_t                 model_step;
        logic [TONE_COUNT-1:0] model_beat;

        int          check_errors;
        int          compare_errors;
        int          test_first_error;
        int          tests_failed;
        integer      seed;
        logic [31:0] r;

        lullaby dut0
        (
                .clock (clock),
                .reset (reset),
                .start (start),
                .stop  (stop),
                .beat  (beat)
        );

        always #(CLOCK_PERIOD / 2) clock = ~clock;

        // Tone k of the scale lights bit k, a rest lights nothing
        function automatic logic [TONE_COUNT-1:0] ref_beat(input step_t step_index);
                note_t note;
                logic [TONE_COUNT-1:0] result;
                note   = song_table[step_index];
                result = '0;
                if (note != NOTE_REST)
                        result = {{(TONE_COUNT-1){1'b0}}, 1'b1} << (int'(note) - 1);
                return result;
        endfunction

        // Player rules with the output one cycle behind the step
        always @(posedge clock or posedge reset)
        begin
                if (reset)
                begin
                        model_on   <= 1'b0;
                        model_step <= '0;
                        model_beat <= '0;
                end
                else
                begin
                        model_beat <= model_on ? ref_beat(model_step) : '0;
                        if (stop)
                        begin
                                model_on   <= 1'b0;
                                model_step <= '0;
                        end
                        else if (!model_on)
                        begin
                                model_on   <= start;
                                model_step <= '0;
                        end
                        else if (model_step == step_t'(SONG_LENGTH - 1))
                                model_step <= '0;
                        else
                                model_step <= model_step + step_t'(1);
                end
        end

        always @(negedge clock)
        begin
                if (!reset)
                begin
                        assert (beat == model_beat)
                        else
                        begin
                                $display("Error at %0t ns: beat %b, model expects %b",
                                         $time, beat, model_beat);
                                compare_errors++;
                        end
                end
        end

        task automatic check_beat(input logic [TONE_COUNT-1:0] expected, input string what);
                assert (beat == expected)
                else
                begin
                        $display("Error at %0t ns: %s, expected %b, got %b",
                                 $time, what, expected, beat);
                        check_errors++;
                end
        endtask

        task automatic sync_to_drive();   // Lands just after a rising edge
                @(posedge clock);
                #1;
        endtask

        task automatic check_silence(input int cycles);
                repeat (cycles)
                begin
                        @(negedge clock);
                        check_beat('0, "beat should be silent");
                end
        endtask

        task automatic check_play(input int first, input int count);
                for (int k = 0; k < count; k++)
                begin
                        @(negedge clock);
                        check_beat(ref_beat(step_t'((first + k) % SONG_LENGTH)), "wrong note");
                end
        endtask

        task automatic start_and_play(input int count);
                start = 1'b1;
                sync_to_drive();
                start = 1'b0;
                @(negedge clock);
                check_beat('0, "beat should be silent before the first note");
                check_play(0, count);
                sync_to_drive();
        endtask

        // The note at step_now is still heard once, then silence
        task automatic stop_and_silence(input int step_now, input int cycles, input logic with_start);
                stop  = 1'b1;
                start = with_start;
                sync_to_drive();
                stop  = 1'b0;
                start = 1'b0;
                @(negedge clock);
                check_beat(ref_beat(step_t'(step_now)), "note at the stop edge");
                check_silence(cycles);
                sync_to_drive();
        endtask

        task automatic begin_test();
                test_first_error = check_errors + compare_errors;
        endtask

        task automatic report_test(input int number, input string name);
                int errors;
                errors = check_errors + compare_errors - test_first_error;
                if (errors == 0)
                        $display("Test %0d (%s) passed", number, name);
                else
                begin
                        $display("Test %0d (%s) failed with %0d errors", number, name, errors);
                        tests_failed++;
                end
        endtask

        initial
        begin
                #(WATCHDOG_CYCLES * CLOCK_PERIOD);
                $display("Simulation timed out after %0d cycles", WATCHDOG_CYCLES);
                $display("ERRORS FOUND");
                $finish;
        end

        initial
        begin
                clock          = 1'b0;
                reset          = 1'b1;
                start          = 1'b0;
                stop           = 1'b0;
                check_errors   = 0;
                compare_errors = 0;
                tests_failed   = 0;
                seed           = 32'h2e2c;
                repeat (16) @(posedge clock);
                #1;
                reset = 1'b0;

                begin_test();
                check_silence(50);
                sync_to_drive();
                report_test(1, "silent after reset");

                begin_test();
                start_and_play(2 * SONG_LENGTH + 1);   // Two passes and the wrap to step 0
                stop_and_silence((2 * SONG_LENGTH + 2) % SONG_LENGTH, 10, 1'b0);
                report_test(2, "full song with wrap");

                begin_test();
                start_and_play(40);
                stop_and_silence(41, 30, 1'b0);
                start_and_play(20);
                stop_and_silence(21, 10, 1'b0);
                report_test(3, "stop mid song and restart");

                begin_test();
                start_and_play(10);
                start = 1'b1;   // Held high while playing
                check_play(10, 20);
                sync_to_drive();
                start = 1'b0;
                check_play(30, 5);
                sync_to_drive();
                stop_and_silence(36, 10, 1'b1);
                start = 1'b1;
                stop  = 1'b1;
                sync_to_drive();
                start = 1'b0;
                stop  = 1'b0;
                check_silence(10);
                sync_to_drive();
                start_and_play(5);
                stop_and_silence(6, 5, 1'b0);
                report_test(4, "start ignored while playing, stop wins");

                begin_test();
                for (int i = 0; i < 4000; i++)
                begin
                        r     = $random(seed);
                        start = (r[3:0] == 4'd0);
                        stop  = (r[11:4] == 8'd0);
                        sync_to_drive();
                end
                start = 1'b0;
                stop  = 1'b0;
                repeat (4) sync_to_drive();
                report_test(5, "random start and stop");

                $display("Tests run: 5, failed: %0d, errors: %0d",
                         tests_failed, check_errors + compare_errors);
                if (check_errors + compare_errors == 0)
                        $display("NO ERRORS");
                else
                        $display("ERRORS FOUND");
                $finish;
        end

endmodule

/* lullaby.f */
+incdir+verilog
verilog/lullaby_pkg.sv
verilog/player_control.sv
verilog/song_rom.sv
verilog/lullaby.sv
sim/lullaby_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the lullaby testbench with Verilator, runs it and checks the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f lullaby.f --top-module lullaby_tb -o lullaby_sim
if [ $? -ne 0 ]; then
        echo "Verilator build failed"
        exit 1
fi

output=$(./obj_dir/lullaby_sim)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
        echo "Simulation exited with status $status"
        exit 1
fi

if printf '%s\n' "$output" | grep -qx "NO ERRORS"; then
        exit 0
else
        exit 1
fi
